// File: dv/cnn_pool_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "cnn_pool_cfg.svh"

module cnn_pool_checker (
  input logic                                          clk,
  input logic                                          reset,
  input cnn_pool_pkg::trans_t                          trans,
  input logic                                          ready_in,
  input logic                                          sel,
  input logic [3:0]                                    prot,
  input logic                                          hwrite,
  input logic [31:0]                                   addr,
  input logic [31:0]                                   wdata,
  input logic                                          resp,
  input logic                                          finish,
  input cnn_pool_pkg::weight_set_t                     wgt_mem,
  input cnn_pool_pkg::pixel_t [`IMG_DIM*`IMG_DIM-1:0]  img_mem
);

  int   error_count = 0;
  int   missing_count = 0;
  int   timeout_count = 0;
  int   wr_seen;
  int   exp_const; // every output of a uniform image, -1 otherwise
  logic finish_seen;
  logic resp_prev;

  // 3x3 dot product, scaled, rectified and saturated, then max over the 2x2 block
  function automatic int pooled_value(input int idx);
    int row;
    int col;
    int sum;
    int val;
    int best;
    best = 0;
    for (int win = 0; win < 4; win++) begin
      row = (idx / `POOL_DIM) * 2 + win / 2;
      col = (idx % `POOL_DIM) * 2 + win % 2;
      sum = 0;
      for (int t = 0; t < 9; t++) begin
        sum += int'(wgt_mem[t]) * int'(img_mem[(row + t / 3) * `IMG_DIM + col + t % 3]);
      end
      val = sum >>> `ACC_SHIFT;
      val = (val < 0) ? 0 : (val > `RELU_MAX) ? `RELU_MAX : val;
      if (val > best) begin
        best = val;
      end
    end
    return best;
  endfunction

  task automatic check_write();
    logic [7:0]  exp;
    logic [31:0] exp_addr;
    if (wr_seen >= `OUT_COUNT) begin
      error_count++;
      $display("write number %0d is beyond the %0d outputs", wr_seen + 1, `OUT_COUNT);
    end else begin
      exp      = 8'(pooled_value(wr_seen));
      exp_addr = `OUT_BASE + 32'(wr_seen) * 4;
      if (addr !== exp_addr || wdata !== {4{exp}}) begin
        error_count++;
        $display("mismatch at %0t ns: output %0d wrote %h to %h, expected %h to %h",
                 $time, wr_seen, wdata, addr, {4{exp}}, exp_addr);
      end else if (exp_const >= 0 && wdata[7:0] !== 8'(exp_const)) begin
        error_count++;
        $display("mismatch at %0t ns: output %0d is %0d, uniform image gives %0d",
                 $time, wr_seen, wdata[7:0], exp_const);
      end
    end
  endtask

  task automatic begin_case(input int value);
    wr_seen     = 0;
    finish_seen = 1'b0;
    exp_const   = value;
  endtask

  task automatic end_case();
    if (wr_seen < `OUT_COUNT) begin
      missing_count += `OUT_COUNT - wr_seen;
      $display("only %0d of %0d output writes were seen", wr_seen, `OUT_COUNT);
    end
  endtask

  task automatic note_timeout(input int case_idx);
    timeout_count++;
    $display("case %0d timed out waiting for finish", case_idx);
  endtask

  task automatic note_bad_read(input logic [31:0] a);
    error_count++;
    $display("read from address %h outside the weight and image regions", a);
  endtask

  always @(posedge clk) begin
    if (reset) begin
      if (trans == cnn_pool_pkg::trans_nonseq && finish_seen) begin
        error_count++;
        $display("bus transfer started after finish");
      end
      // ready_in marks the address phase only
      if (ready_in !== (trans == cnn_pool_pkg::trans_nonseq)) begin
        error_count++;
        $display("mismatch at %0t ns: ready_in is %b while trans is %0d",
                 $time, ready_in, trans);
      end
      if (sel && prot !== (hwrite ? `PROT_WRITE : `PROT_READ)) begin
        error_count++;
        $display("mismatch at %0t ns: prot is %0d during a transfer with hwrite %b",
                 $time, prot, hwrite);
      end
      if (!sel && (prot !== 4'd0 || hwrite !== 1'b0)) begin
        error_count++;
        $display("mismatch at %0t ns: prot %0d and hwrite %b while sel is low",
                 $time, prot, hwrite);
      end
      if (trans == cnn_pool_pkg::trans_nonseq && hwrite) begin
        if (resp_prev) begin // resp as seen at the launching edge
          error_count++;
          $display("write address phase began while resp was high");
        end
        check_write();
        wr_seen++;
      end
      if (finish && !finish_seen && wr_seen != `OUT_COUNT) begin
        error_count++;
        $display("finish rose after %0d writes instead of %0d", wr_seen, `OUT_COUNT);
      end
      if (!finish && finish_seen) begin
        error_count++;
        $display("finish fell before reset");
      end
      finish_seen = finish_seen | finish;
    end
    resp_prev = resp;
  end

endmodule

`default_nettype wire

// File: dv/cnn_pool_props.sv
`timescale 1ns/1ns
`default_nettype none

module cnn_pool_props (
  input logic                 clk,
  input logic                 reset,
  input logic                 rd_req,
  input cnn_pool_pkg::trans_t trans,
  input logic                 sel,
  input logic                 hwrite,
  input logic                 finish
);

  int   fail_count = 0;
  logic started; // a read was requested since the last reset

  always_ff @(posedge clk) begin
    if (!reset) begin
      started <= 1'b0;
    end else if (rd_req) begin
      started <= 1'b1;
    end
  end

  a_nonseq_single: assert property (@(posedge clk) disable iff (!reset)
    trans == cnn_pool_pkg::trans_nonseq |=> trans != cnn_pool_pkg::trans_nonseq)
    else begin
      $error("address phase lasted two cycles");
      fail_count++;
    end

  a_sel_in_address: assert property (@(posedge clk) disable iff (!reset)
    trans == cnn_pool_pkg::trans_nonseq |-> sel)
    else begin
      $error("sel low during an address phase");
      fail_count++;
    end

  a_quiet_before_start: assert property (@(posedge clk) disable iff (!reset)
    !started |-> trans == cnn_pool_pkg::trans_idle && !hwrite && !finish)
    else begin
      $error("bus activity or finish before start");
      fail_count++;
    end

endmodule

bind bus_master cnn_pool_props u_props (
  .clk    (clk),
  .reset  (reset),
  .rd_req (rd_req),
  .trans  (trans),
  .sel    (sel),
  .hwrite (hwrite),
  .finish (finish)
);

`default_nettype wire

// File: dv/cnn_pool_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "cnn_pool_cfg.svh"

module cnn_pool_tb;

  localparam int fill_random = 0;
  localparam int fill_ramp   = 1;
  localparam int fill_zero   = 2;
  localparam int fill_full   = 3;
  localparam int max_cycles  = 100000; // per case

  typedef struct {
    int taps [9];
    int fill;
    int stall_pct;
    int exp_const; // every output for a uniform image, -1 if not uniform
  } case_t;

  logic                                         clk = 1'b0;
  logic                                         reset;
  logic                                         start;
  logic [31:0]                                  rdata;
  logic                                         ready_out;
  logic                                         resp;
  logic [31:0]                                  addr;
  logic                                         ready_in;
  cnn_pool_pkg::trans_t                         trans;
  logic                                         sel;
  logic [3:0]                                   prot;
  logic                                         hwrite;
  logic [31:0]                                  wdata;
  logic                                         finish;
  int                                           stall_pct;
  cnn_pool_pkg::weight_set_t                    wgt_mem;
  cnn_pool_pkg::pixel_t [`IMG_DIM*`IMG_DIM-1:0] img_mem;
  case_t                                        case_q [$];

  always #4 clk = ~clk;

  cnn_pool_top uut (
    .clk(clk), .reset(reset), .start(start), .rdata(rdata), .ready_out(ready_out),
    .resp(resp), .addr(addr), .ready_in(ready_in), .trans(trans), .sel(sel),
    .prot(prot), .hwrite(hwrite), .wdata(wdata), .finish(finish)
  );

  cnn_pool_checker chk (
    .clk(clk), .reset(reset), .trans(trans), .ready_in(ready_in), .sel(sel),
    .prot(prot), .hwrite(hwrite), .addr(addr), .wdata(wdata), .resp(resp),
    .finish(finish), .wgt_mem(wgt_mem), .img_mem(img_mem)
  );

  task automatic serve_read(input logic [31:0] a);
    cnn_pool_pkg::bus_word_u word;
    word = {8'h00, ~a[23:0]}; // low lanes are filler
    if (a >= `WGT_BASE && a < `WGT_BASE + 36) begin
      word.wgt.w = wgt_mem[(a - `WGT_BASE) >> 2];
    end else if (a >= `IMG_BASE && a < `IMG_BASE + 4 * `IMG_DIM * `IMG_DIM) begin
      word.pix.p = img_mem[(a - `IMG_BASE) >> 2];
    end else begin
      chk.note_bad_read(a);
    end
    rdata = word;
  endtask

  // memory slave, answers the address phase and adds wait states and resp
  always @(posedge clk) begin
    #1;
    if (trans == cnn_pool_pkg::trans_nonseq && !hwrite) begin
      serve_read(addr);
    end
    ready_out = ($urandom % 100) >= stall_pct;
    resp      = ($urandom % 100) < stall_pct / 3;
  end

  task automatic add_case(input int taps [9], input int fill, input int stall, input int value);
    case_t c;
    c.taps      = taps;
    c.fill      = fill;
    c.stall_pct = stall;
    c.exp_const = value;
    case_q.push_back(c);
  endtask

  task automatic load_case(input case_t c);
    int i;
    for (i = 0; i < 9; i++) begin
      wgt_mem[i] = cnn_pool_pkg::weight_t'(c.taps[i]);
    end
    for (i = 0; i < `IMG_DIM * `IMG_DIM; i++) begin
      case (c.fill)
        fill_random: img_mem[i] = 8'($urandom);
        fill_ramp:   img_mem[i] = 8'(i * 2 + 1);
        fill_zero:   img_mem[i] = 8'h00;
        default:     img_mem[i] = 8'hff;
      endcase
    end
    stall_pct = c.stall_pct;
  endtask

  initial begin
    int cycles;
    void'($urandom(32'h3185_bb44));
    reset     = 1'b0;
    start     = 1'b0;
    rdata     = 32'h0;
    ready_out = 1'b1;
    resp      = 1'b0;
    stall_pct = 0;
    add_case('{1, 2, 1, 2, 4, 2, 1, 2, 1}, fill_ramp, 0, -1);
    add_case('{-3, 5, -3, 5, 9, 5, -3, 5, -3}, fill_ramp, 0, -1);
    add_case('{1, 1, 1, 1, 1, 1, 1, 1, 1}, fill_full, 0, 17);
    add_case('{100, 100, 100, 100, -20, 100, 100, 100, 100}, fill_full, 30, 127);
    add_case('{-90, 10, -90, 10, -90, 10, -90, 10, -90}, fill_full, 30, 0);
    add_case('{12, -7, 20, -15, 30, -9, 4, 11, -2}, fill_random, 0, -1);
    add_case('{127, -128, 127, -128, 127, -128, 127, -128, 127}, fill_random, 40, -1);
    add_case('{1, 2, 1, 2, 4, 2, 1, 2, 1}, fill_ramp, 50, -1); // first row under stalls
    add_case('{3, -2, 1, 0, 4, 0, -1, 2, 1}, fill_zero, 20, 0);
    add_case('{3, -2, 1, 0, 4, 0, -1, 2, 1}, fill_full, 20, 15);
    foreach (case_q[k]) begin
      load_case(case_q[k]);
      chk.begin_case(case_q[k].exp_const);
      repeat (10) @(posedge clk);
      #1 reset = 1'b1;
      @(posedge clk);
      #1 start = 1'b1;
      @(posedge clk);
      #1 start = 1'b0;
      cycles = 0;
      while (!finish && cycles < max_cycles) begin
        @(posedge clk);
        #1;
        cycles++;
      end
      if (!finish) begin
        chk.note_timeout(k);
      end
      repeat (20) @(posedge clk); // finish holds and the bus stays quiet
      #1 reset = 1'b0;
      chk.end_case();
    end
    $display("errors %0d, missing writes %0d, timeouts %0d, assertion failures %0d",
             chk.error_count, chk.missing_count, chk.timeout_count,
             uut.u_bus.u_props.fail_count);
    if (chk.error_count + chk.missing_count + chk.timeout_count
        + uut.u_bus.u_props.fail_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+source
source/cnn_pool_pkg.sv
source/window_fetch.sv
source/conv_pool_engine.sv
source/bus_master.sv
source/cnn_pool_top.sv
dv/cnn_pool_props.sv
dv/cnn_pool_checker.sv
dv/cnn_pool_tb.sv

// File: source/bus_master.sv
`timescale 1ns/1ns
`default_nettype none

`include "cnn_pool_cfg.svh"

module bus_master (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 rd_req,
  input  logic [31:0]          rd_addr,
  output logic                 rd_done,
  input  logic                 out_valid,
  input  logic [7:0]           pool_value,
  output logic [31:0]          addr,
  output logic                 ready_in,
  output cnn_pool_pkg::trans_t trans,
  output logic                 sel,
  output logic [3:0]           prot,
  output logic                 hwrite,
  output logic [31:0]          wdata,
  input  logic                 ready_out,
  input  logic                 resp,
  output logic                 finish
);

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_turn = 2'd1; // cycle after the address phase
  localparam logic [1:0] st_data = 2'd2;
  localparam logic [1:0] st_done = 2'd3;

  logic [1:0]  state;
  logic        pend_valid;
  logic [7:0]  pend_data;
  logic [15:0] wr_count;
  logic        launch_wr;
  logic        launch_rd;
  logic        data_done;

  // a waiting write goes out before any further read
  assign launch_wr = (state == st_idle) && pend_valid && ready_out && !resp;
  assign launch_rd = (state == st_idle) && !pend_valid && rd_req && ready_out;
  assign data_done = (state == st_data) && ready_out;
  assign rd_done   = data_done && !hwrite; // rdata valid in this cycle

  always_ff @(posedge clk) begin
    if (!reset) begin
      state      <= st_idle;
      trans      <= cnn_pool_pkg::trans_idle;
      ready_in   <= 1'b0;
      sel        <= 1'b0;
      prot       <= 4'd0;
      hwrite     <= 1'b0;
      finish     <= 1'b0;
      pend_valid <= 1'b0;
      wr_count   <= 16'd0;
    end else begin
      case (state)
        st_idle: begin
          if (launch_wr || launch_rd) begin
            trans    <= cnn_pool_pkg::trans_nonseq;
            ready_in <= 1'b1;
            sel      <= 1'b1;
            hwrite   <= launch_wr;
            prot     <= launch_wr ? `PROT_WRITE : `PROT_READ;
            state    <= st_turn;
          end
          if (launch_wr) begin
            pend_valid <= 1'b0;
          end
        end
        st_turn: begin
          trans    <= cnn_pool_pkg::trans_idle;
          ready_in <= 1'b0;
          state    <= st_data;
        end
        st_data: begin
          if (data_done) begin
            sel    <= 1'b0;
            prot   <= 4'd0;
            hwrite <= 1'b0;
            state  <= st_idle;
            if (hwrite) begin
              wr_count <= wr_count + 16'd1;
              if (wr_count == 16'(`OUT_COUNT - 1)) begin
                finish <= 1'b1; // held until reset
                state  <= st_done;
              end
            end
          end
        end
        st_done: state <= st_done;
        default: state <= st_idle;
      endcase
      if (out_valid) begin
        pend_valid <= 1'b1;
      end
    end
  end

  // address and data words of the transfer being launched
  always_ff @(posedge clk) begin
    if (out_valid) begin
      pend_data <= pool_value;
    end
    if (launch_wr) begin
      addr  <= `OUT_BASE + 32'(wr_count) * 4;
      wdata <= {4{pend_data}}; // same byte on all lanes
    end else if (launch_rd) begin
      addr <= rd_addr;
    end
  end

endmodule

`default_nettype wire

// File: source/cnn_pool_cfg.svh
`ifndef CNN_POOL_CFG_SVH
`define CNN_POOL_CFG_SVH

// image geometry, square image with one pixel per bus word
`define IMG_DIM 10
`define CONV_DIM (`IMG_DIM - 2)
`define POOL_DIM (`CONV_DIM / 2)
`define OUT_COUNT (`POOL_DIM * `POOL_DIM)

// memory map, byte addresses
`define WGT_BASE 32'h4001_0000
`define IMG_BASE 32'h4000_0000
`define OUT_BASE 32'h4002_0000

// dot product is scaled down before relu
`define ACC_SHIFT 7
`define RELU_MAX 127

// protection codes on the bus
`define PROT_READ 4'd1
`define PROT_WRITE 4'd9

`endif

// File: source/cnn_pool_pkg.sv
`default_nettype none

package cnn_pool_pkg;

  typedef logic signed [7:0] weight_t;
  typedef weight_t [8:0] weight_set_t; // tap 0 is top left, row-major

  typedef logic [7:0] pixel_t;

  // read data carries one byte in the top lane, decoded per region
  typedef union packed {
    struct packed {
      weight_t     w;
      logic [23:0] unused;
    } wgt;
    struct packed {
      pixel_t      p;
      logic [23:0] unused;
    } pix;
  } bus_word_u;

  typedef logic signed [19:0] acc_t; // 9 taps of 8x9 bit products fit

  typedef enum logic [1:0] {
    trans_idle   = 2'b00,
    trans_nonseq = 2'b10
  } trans_t;

endpackage

`default_nettype wire

// File: source/cnn_pool_top.sv
`timescale 1ns/1ns
`default_nettype none

module cnn_pool_top (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  logic [31:0]          rdata,
  input  logic                 ready_out,
  input  logic                 resp,
  output logic [31:0]          addr,
  output logic                 ready_in,
  output cnn_pool_pkg::trans_t trans,
  output logic                 sel,
  output logic [3:0]           prot,
  output logic                 hwrite,
  output logic [31:0]          wdata,
  output logic                 finish
);

  logic                      rd_req;
  logic [31:0]               rd_addr;
  logic                      rd_done;
  cnn_pool_pkg::weight_set_t weights;
  cnn_pool_pkg::pixel_t      pixel;
  logic                      pix_valid;
  logic                      out_valid;
  logic [7:0]                pool_value;

  window_fetch u_fetch (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .rd_req    (rd_req),
    .rd_addr   (rd_addr),
    .rd_done   (rd_done),
    .rdata     (rdata),
    .weights   (weights),
    .pixel     (pixel),
    .pix_valid (pix_valid)
  );

  conv_pool_engine u_engine (
    .clk        (clk),
    .reset      (reset),
    .weights    (weights),
    .pixel      (pixel),
    .pix_valid  (pix_valid),
    .out_valid  (out_valid),
    .pool_value (pool_value)
  );

  bus_master u_bus (
    .clk        (clk),
    .reset      (reset),
    .rd_req     (rd_req),
    .rd_addr    (rd_addr),
    .rd_done    (rd_done),
    .out_valid  (out_valid),
    .pool_value (pool_value),
    .addr       (addr),
    .ready_in   (ready_in),
    .trans      (trans),
    .sel        (sel),
    .prot       (prot),
    .hwrite     (hwrite),
    .wdata      (wdata),
    .ready_out  (ready_out),
    .resp       (resp),
    .finish     (finish)
  );

endmodule

`default_nettype wire

// File: source/conv_pool_engine.sv
`timescale 1ns/1ns
`default_nettype none

`include "cnn_pool_cfg.svh"

module conv_pool_engine (
  input  logic                      clk,
  input  logic                      reset,
  input  cnn_pool_pkg::weight_set_t weights,
  input  cnn_pool_pkg::pixel_t      pixel,
  input  logic                      pix_valid,
  output logic                      out_valid,
  output logic [7:0]                pool_value
);

  logic [3:0]         tap;
  logic [1:0]         win;
  cnn_pool_pkg::acc_t acc;
  cnn_pool_pkg::acc_t product;
  cnn_pool_pkg::acc_t acc_next;
  cnn_pool_pkg::acc_t shifted;
  logic signed [8:0]  pix_s;
  logic [7:0]         relu_val;
  logic [7:0]         max_val;
  logic [7:0]         max_next;

  assign pix_s = {1'b0, pixel}; // pixels are unsigned

  assign product  = cnn_pool_pkg::acc_t'(cnn_pool_pkg::weight_t'(weights[tap]))
                    * cnn_pool_pkg::acc_t'(pix_s);
  assign acc_next = acc + product;
  assign shifted  = acc_next >>> `ACC_SHIFT; // keeps sign

  // relu, then saturate to the byte range
  always_comb begin
    if (shifted[19]) begin
      relu_val = 8'd0;
    end else if (shifted > cnn_pool_pkg::acc_t'(`RELU_MAX)) begin
      relu_val = 8'(`RELU_MAX);
    end else begin
      relu_val = shifted[7:0];
    end
  end

  assign max_next = (relu_val > max_val) ? relu_val : max_val;

  always_ff @(posedge clk) begin
    if (!reset) begin
      tap       <= 4'd0;
      win       <= 2'd0;
      acc       <= '0;
      max_val   <= 8'd0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= 1'b0;
      if (pix_valid) begin
        if (tap == 4'd8) begin // window complete
          tap <= 4'd0;
          acc <= '0;
          win <= win + 2'd1;
          if (win == 2'd3) begin
            out_valid <= 1'b1;
            max_val   <= 8'd0;
          end else begin
            max_val <= max_next;
          end
        end else begin
          tap <= tap + 4'd1;
          acc <= acc_next;
        end
      end
    end
  end

  // pooled byte for the write-back
  always_ff @(posedge clk) begin
    if (pix_valid && tap == 4'd8 && win == 2'd3) begin
      pool_value <= max_next;
    end
  end

endmodule

`default_nettype wire

// File: source/window_fetch.sv
`timescale 1ns/1ns
`default_nettype none

`include "cnn_pool_cfg.svh"

module window_fetch (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      start,
  output logic                      rd_req,
  output logic [31:0]               rd_addr,
  input  logic                      rd_done,
  input  cnn_pool_pkg::bus_word_u   rdata,
  output cnn_pool_pkg::weight_set_t weights,
  output cnn_pool_pkg::pixel_t      pixel,
  output logic                      pix_valid
);

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_wgt  = 2'd1;
  localparam logic [1:0] st_img  = 2'd2;

  localparam logic [7:0] last_pool = 8'(`POOL_DIM - 1);

  logic [1:0]  state;
  logic [3:0]  wgt_idx;
  logic [7:0]  pool_row;
  logic [7:0]  pool_col;
  logic [1:0]  win; // bit 0 moves right, bit 1 moves down
  logic [1:0]  tap_row;
  logic [1:0]  tap_col;
  logic [31:0] img_row;
  logic [31:0] img_col;
  logic [31:0] pix_index;

  // pixel position of the current tap
  assign img_row   = 32'(pool_row) * 2 + 32'(win[1]) + 32'(tap_row);
  assign img_col   = 32'(pool_col) * 2 + 32'(win[0]) + 32'(tap_col);
  assign pix_index = img_row * `IMG_DIM + img_col;

  // counters only move on rd_done so the address holds during a transfer
  assign rd_addr = (state == st_wgt) ? `WGT_BASE + 32'(wgt_idx) * 4
                                     : `IMG_BASE + pix_index * 4;

  always_ff @(posedge clk) begin
    if (!reset) begin
      state     <= st_idle;
      rd_req    <= 1'b0;
      pix_valid <= 1'b0;
      wgt_idx   <= 4'd0;
      pool_row  <= 8'd0;
      pool_col  <= 8'd0;
      win       <= 2'd0;
      tap_row   <= 2'd0;
      tap_col   <= 2'd0;
    end else begin
      pix_valid <= 1'b0;
      case (state)
        st_idle: begin
          if (start) begin
            state   <= st_wgt;
            rd_req  <= 1'b1;
            wgt_idx <= 4'd0;
          end
        end
        st_wgt: begin
          if (rd_done) begin
            if (wgt_idx == 4'd8) begin // weights done, image walk from origin
              state    <= st_img;
              wgt_idx  <= 4'd0;
              pool_row <= 8'd0;
              pool_col <= 8'd0;
              win      <= 2'd0;
              tap_row  <= 2'd0;
              tap_col  <= 2'd0;
            end else begin
              wgt_idx <= wgt_idx + 4'd1;
            end
          end
        end
        st_img: begin
          if (rd_done) begin
            pix_valid <= 1'b1;
            if (tap_col != 2'd2) begin
              tap_col <= tap_col + 2'd1;
            end else begin
              tap_col <= 2'd0;
              if (tap_row != 2'd2) begin
                tap_row <= tap_row + 2'd1;
              end else begin
                tap_row <= 2'd0;
                win     <= win + 2'd1; // wraps to 0 after the 4th window
                if (win == 2'd3) begin
                  if (pool_col != last_pool) begin
                    pool_col <= pool_col + 8'd1;
                  end else begin
                    pool_col <= 8'd0;
                    if (pool_row != last_pool) begin
                      pool_row <= pool_row + 8'd1;
                    end else begin
                      state  <= st_idle; // last output fetched
                      rd_req <= 1'b0;
                    end
                  end
                end
              end
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // returned data, top byte only
  always_ff @(posedge clk) begin
    if (rd_done && state == st_wgt) begin
      weights[wgt_idx] <= rdata.wgt.w;
    end
    if (rd_done && state == st_img) begin
      pixel <= rdata.pix.p;
    end
  end

endmodule

`default_nettype wire
